//--- design/rd_batch_pkg.sv
package rd_batch_pkg;

    // axi field widths, fixed for the whole subsystem
    localparam int id_w   = 3;          // 8 ids
    localparam int addr_w = 32;
    localparam int len_w  = 8;          // burst has len + 1 beats
    localparam int data_w = 32;

    localparam int id_num = 1 << id_w;  // number of distinct ids

    // read request, also used as the AR payload (43 bits)
    typedef struct packed {
        logic [id_w-1:0]   id;
        logic [addr_w-1:0] addr;
        logic [len_w-1:0]  len;
    } rd_req_t;

    // R channel payload (36 bits)
    typedef struct packed {
        logic [id_w-1:0]   id;
        logic [data_w-1:0] data;
        logic              last;
    } r_beat_t;

    // output stream payload, R beat plus the length check (37 bits)
    typedef struct packed {
        logic [id_w-1:0]   id;
        logic [data_w-1:0] data;
        logic              last;
        logic              len_err;
    } out_beat_t;

    // request generator FSM
    typedef enum logic [2:0] {
        idle,       // wait for a request and room in the id record
        check_id,   // lookup issued to the id record
        result,     // busy is valid here
        set_ar,     // AR valid, waiting for ready
        drop_req    // id still outstanding, pend strobe and pop
    } gen_state_t;

endpackage

//--- design/req_fifo.sv
`timescale 1ns/1ps
module req_fifo #(
    parameter int depth = 4
) (
    input  logic                  clock,
    input  logic                  rst_n,
    input  logic                  wr_en,
    input  rd_batch_pkg::rd_req_t wdata,
    input  logic                  rd_en,
    output rd_batch_pkg::rd_req_t rdata,
    output logic                  empty,
    output logic                  full
);

    localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
    localparam int cnt_w = $clog2(depth + 1);

    rd_batch_pkg::rd_req_t mem [depth];     // payload storage, no reset

    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [cnt_w-1:0] count;                // words held
    logic             do_wr;
    logic             do_rd;

    assign empty = (count == '0);
    assign full  = (count == cnt_w'(depth));

    assign do_wr = wr_en && !full;          // write while full is lost
    assign do_rd = rd_en && !empty;

    assign rdata = mem[rd_ptr];             // head word, valid while not empty

    always_ff @(posedge clock) begin
        if (do_wr) begin
            mem[wr_ptr] <= wdata;
        end
    end

    // pointers wrap at depth so any depth works, not only powers of two
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;    // both or neither
            endcase
        end
    end

endmodule

//--- design/id_record.sv
`timescale 1ns/1ps
module id_record #(
    parameter int max_outstanding = 8
) (
    input  logic                          clock,
    input  logic                          rst_n,
    input  logic                          set_en,     // AR handshake
    input  logic [rd_batch_pkg::id_w-1:0] set_id,
    input  logic                          clear_en,   // last R beat handshake
    input  logic [rd_batch_pkg::id_w-1:0] clear_id,
    input  logic                          lookup_en,
    input  logic [rd_batch_pkg::id_w-1:0] lookup_id,
    output logic                          busy,       // one cycle after lookup_en
    output logic                          full
);

    localparam int cnt_w = $clog2(rd_batch_pkg::id_num + 1);

    logic [rd_batch_pkg::id_num-1:0] pend_bits;       // one bit per outstanding id
    logic [rd_batch_pkg::id_num-1:0] pend_bits_nxt;
    logic [cnt_w-1:0]                pend_cnt;

    // population count of the next bitmap keeps the counter exact
    // even when set and clear land in the same cycle
    function automatic logic [cnt_w-1:0] ones(input logic [rd_batch_pkg::id_num-1:0] v);
        logic [cnt_w-1:0] n;
        n = '0;
        for (int i = 0; i < rd_batch_pkg::id_num; i++) begin
            n = n + cnt_w'(v[i]);
        end
        return n;
    endfunction

    always_comb begin
        pend_bits_nxt = pend_bits;
        if (clear_en) pend_bits_nxt[clear_id] = 1'b0;   // release
        if (set_en)   pend_bits_nxt[set_id]   = 1'b1;   // issue
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            pend_bits <= '0;
            pend_cnt  <= '0;
            busy      <= 1'b0;
        end else begin
            pend_bits <= pend_bits_nxt;
            pend_cnt  <= ones(pend_bits_nxt);
            if (lookup_en) begin
                busy <= pend_bits[lookup_id];   // registered lookup
            end
        end
    end

    assign full = (pend_cnt >= cnt_w'(max_outstanding));    // outstanding limit

endmodule

//--- design/rd_batch_gen.sv
`timescale 1ns/1ps
module rd_batch_gen (
    input  logic                          clock,
    input  logic                          rst_n,
    // fifo head
    input  rd_batch_pkg::rd_req_t         head,
    input  logic                          empty,
    output logic                          pop,
    // id record
    output logic                          lookup_en,
    output logic [rd_batch_pkg::id_w-1:0] lookup_id,
    input  logic                          busy,
    input  logic                          rec_full,
    // AR channel
    output logic                          ar_valid,
    output rd_batch_pkg::rd_req_t         ar,
    input  logic                          ar_ready,
    // dropped request report
    output logic                          pend_en,
    output logic [rd_batch_pkg::id_w-1:0] pend_id
);

    rd_batch_pkg::gen_state_t state;
    rd_batch_pkg::gen_state_t state_nxt;

    logic ar_fire;

    assign ar_fire = ar_valid && ar_ready;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            state <= rd_batch_pkg::idle;
        end else begin
            state <= state_nxt;
        end
    end

    // one request at a time, the bursts themselves overlap
    always_comb begin
        state_nxt = state;
        case (state)
            rd_batch_pkg::idle: begin
                // hold off while the record has no room
                if (!empty && !rec_full) begin
                    state_nxt = rd_batch_pkg::check_id;
                end
            end
            rd_batch_pkg::check_id: begin
                state_nxt = rd_batch_pkg::result;   // lookup in flight
            end
            rd_batch_pkg::result: begin
                if (busy) begin
                    state_nxt = rd_batch_pkg::drop_req;     // id still in use
                end else begin
                    state_nxt = rd_batch_pkg::set_ar;
                end
            end
            rd_batch_pkg::set_ar: begin
                if (ar_fire) begin
                    state_nxt = rd_batch_pkg::idle;
                end
            end
            rd_batch_pkg::drop_req: begin
                state_nxt = rd_batch_pkg::idle;     // single cycle
            end
            default: begin
                state_nxt = rd_batch_pkg::idle;
            end
        endcase
    end

    // strobes registered from the next state, so each one
    // lines up exactly with the state it belongs to
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            lookup_en <= 1'b0;
            ar_valid  <= 1'b0;
            pend_en   <= 1'b0;
        end else begin
            lookup_en <= (state_nxt == rd_batch_pkg::check_id);
            ar_valid  <= (state_nxt == rd_batch_pkg::set_ar);
            pend_en   <= (state_nxt == rd_batch_pkg::drop_req);
        end
    end

    // head only moves on pop, so it is the AR payload as is
    assign ar        = head;
    assign lookup_id = head.id;
    assign pend_id   = head.id;

    // retire the head on the AR handshake or on a drop
    assign pop = ar_fire || pend_en;

endmodule

//--- design/rd_resp_track.sv
`timescale 1ns/1ps
module rd_resp_track (
    input  logic                           clock,
    input  logic                           rst_n,
    // issued bursts
    input  logic                           ar_fire,
    input  logic [rd_batch_pkg::id_w-1:0]  ar_id,
    input  logic [rd_batch_pkg::len_w-1:0] ar_len,
    // R channel
    input  logic                           r_valid,
    input  rd_batch_pkg::r_beat_t          r,
    output logic                           r_ready,
    // output stream
    output logic                           out_valid,
    output rd_batch_pkg::out_beat_t        out,
    input  logic                           out_ready,
    // id release
    output logic                           clear_en,
    output logic [rd_batch_pkg::id_w-1:0]  clear_id
);

    logic [rd_batch_pkg::len_w-1:0] len_tab [rd_batch_pkg::id_num];  // issued len per id
    logic [rd_batch_pkg::len_w-1:0] beat_cnt [rd_batch_pkg::id_num]; // beats seen so far

    logic                           beat_fire;
    logic [rd_batch_pkg::len_w-1:0] cur_cnt;    // index of the current beat
    logic                           at_final;   // current beat is the last expected one
    logic                           burst_end;
    logic                           len_err;

    assign r_ready   = out_ready;               // stall straight through
    assign out_valid = r_valid;
    assign beat_fire = r_valid && out_ready;

    assign cur_cnt  = beat_cnt[r.id];
    assign at_final = (cur_cnt == len_tab[r.id]);

    // early last, or last missing on the final expected beat
    assign len_err   = r.last ^ at_final;
    assign burst_end = r.last || at_final;

    assign out.id      = r.id;
    assign out.data    = r.data;
    assign out.last    = r.last;
    assign out.len_err = len_err;

    assign clear_en = beat_fire && burst_end;   // free the id for reuse
    assign clear_id = r.id;

    always_ff @(posedge clock) begin
        if (ar_fire) begin
            len_tab[ar_id] <= ar_len;
        end
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < rd_batch_pkg::id_num; i++) begin
                beat_cnt[i] <= '0;
            end
        end else if (beat_fire) begin
            if (burst_end) begin
                beat_cnt[r.id] <= '0;           // ready for the next burst on this id
            end else begin
                beat_cnt[r.id] <= cur_cnt + 1'b1;
            end
        end
    end

endmodule

//--- design/rd_batch_top.sv
`timescale 1ns/1ps
module rd_batch_top #(
    parameter int fifo_depth      = 4,
    parameter int max_outstanding = 8
) (
    input  logic                          clock,
    input  logic                          rst_n,
    // request stream
    input  logic                          req_valid,
    input  rd_batch_pkg::rd_req_t         req,
    output logic                          req_ready,
    // AR channel
    output logic                          ar_valid,
    output rd_batch_pkg::rd_req_t         ar,
    input  logic                          ar_ready,
    // R channel
    input  logic                          r_valid,
    input  rd_batch_pkg::r_beat_t         r,
    output logic                          r_ready,
    // output stream
    output logic                          out_valid,
    output rd_batch_pkg::out_beat_t       out,
    input  logic                          out_ready,
    // dropped request report
    output logic                          pend_en,
    output logic [rd_batch_pkg::id_w-1:0] pend_id
);

    rd_batch_pkg::rd_req_t         head;
    logic                          fifo_empty;
    logic                          fifo_full;
    logic                          pop;
    logic                          lookup_en;
    logic [rd_batch_pkg::id_w-1:0] lookup_id;
    logic                          busy;
    logic                          rec_full;
    logic                          ar_fire;
    logic                          clear_en;
    logic [rd_batch_pkg::id_w-1:0] clear_id;

    assign req_ready = !fifo_full;
    assign ar_fire   = ar_valid && ar_ready;

    req_fifo #(.depth(fifo_depth)) i_fifo (
        .clock (clock),
        .rst_n (rst_n),
        .wr_en (req_valid && req_ready),
        .wdata (req),
        .rd_en (pop),
        .rdata (head),
        .empty (fifo_empty),
        .full  (fifo_full)
    );

    id_record #(.max_outstanding(max_outstanding)) i_rec (
        .clock     (clock),
        .rst_n     (rst_n),
        .set_en    (ar_fire),       // id goes busy on issue
        .set_id    (ar.id),
        .clear_en  (clear_en),
        .clear_id  (clear_id),
        .lookup_en (lookup_en),
        .lookup_id (lookup_id),
        .busy      (busy),
        .full      (rec_full)
    );

    rd_batch_gen i_gen (
        .clock     (clock),
        .rst_n     (rst_n),
        .head      (head),
        .empty     (fifo_empty),
        .pop       (pop),
        .lookup_en (lookup_en),
        .lookup_id (lookup_id),
        .busy      (busy),
        .rec_full  (rec_full),
        .ar_valid  (ar_valid),
        .ar        (ar),
        .ar_ready  (ar_ready),
        .pend_en   (pend_en),
        .pend_id   (pend_id)
    );

    rd_resp_track i_track (
        .clock     (clock),
        .rst_n     (rst_n),
        .ar_fire   (ar_fire),
        .ar_id     (ar.id),
        .ar_len    (ar.len),
        .r_valid   (r_valid),
        .r         (r),
        .r_ready   (r_ready),
        .out_valid (out_valid),
        .out       (out),
        .out_ready (out_ready),
        .clear_en  (clear_en),
        .clear_id  (clear_id)
    );

endmodule

//--- test/tb_axi_rd_slave.sv
`timescale 1ns/1ps
module tb_axi_rd_slave (
    input  logic                  clock,
    input  logic                  rst_n,
    // AR channel
    input  logic                  ar_valid,
    input  rd_batch_pkg::rd_req_t ar,
    output logic                  ar_ready,
    // R channel
    output logic                  r_valid,
    output rd_batch_pkg::r_beat_t r,
    input  logic                  r_ready,
    // gap control from the testbench random source
    input  logic                  ar_gate,    // ar_ready for the next cycle
    input  logic                  r_gate,     // allow a new beat this cycle
    input  logic                  r_hold,     // withhold all R traffic
    input  int                    short_idx   // AR number whose burst ends a beat early
);

    rd_batch_pkg::rd_req_t burst_q [$];       // accepted ARs, served in order
    bit                    short_q [$];
    int                    beat;              // index of the next beat of the head burst
    int                    n_ar;              // ARs accepted since reset
    logic                  shown;             // a beat is still on the bus after this edge

    always @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            ar_ready <= 1'b0;
            r_valid  <= 1'b0;
            r        <= '0;
            burst_q.delete();
            short_q.delete();
            beat = 0;
            n_ar = 0;
        end else begin
            if (ar_valid && ar_ready) begin
                burst_q.push_back(ar);
                short_q.push_back(n_ar == short_idx);
                n_ar++;
            end
            ar_ready <= ar_gate;

            shown = r_valid;
            if (r_valid && r_ready) begin
                shown = 1'b0;
                if (r.last) begin
                    void'(burst_q.pop_front());   // burst done
                    void'(short_q.pop_front());
                    beat = 0;
                end else begin
                    beat++;
                end
            end

            // a presented beat holds until taken, gaps only between beats
            if (!shown) begin
                if (burst_q.size() != 0 && r_gate && !r_hold) begin
                    r_valid <= 1'b1;
                    r.id    <= burst_q[0].id;
                    r.data  <= burst_q[0].addr + beat;
                    // short burst drops its final beat
                    r.last  <= (beat == int'(burst_q[0].len) - int'(short_q[0]));
                end else begin
                    r_valid <= 1'b0;
                end
            end
        end
    end

endmodule

//--- test/tb_rd_batch.sv
`timescale 1ns/1ps
module tb_rd_batch;

    localparam int fifo_depth  = 4;
    localparam int max_out     = 6;       // below the 8 ids, so the record can fill
    localparam int n_tests     = 4;
    localparam int test_cycles = 625;     // budget per test
    localparam int period      = 8;
    localparam int watchdog_ns = n_tests * test_cycles * period;   // 20000 ns

    logic                          clock;
    logic                          rst_n;
    logic                          req_valid;
    rd_batch_pkg::rd_req_t         req;
    logic                          req_ready;
    logic                          ar_valid;
    rd_batch_pkg::rd_req_t         ar;
    logic                          ar_ready;
    logic                          r_valid;
    rd_batch_pkg::r_beat_t         r;
    logic                          r_ready;
    logic                          out_valid;
    rd_batch_pkg::out_beat_t       out;
    logic                          out_ready;
    logic                          pend_en;
    logic [rd_batch_pkg::id_w-1:0] pend_id;
    logic                          ar_gate;
    logic                          r_gate;
    logic                          r_hold;
    int                            short_idx;

    logic [15:0]           lfsr = 16'd50678;
    int                    errors;
    rd_batch_pkg::rd_req_t acc_q [$];     // accepted requests, not yet issued or dropped
    logic [31:0]           exp_addr [8];
    logic [7:0]            exp_len [8];
    bit                    exp_short [8];
    bit                    busy_set [8];  // ids the testbench sees as outstanding
    int                    beat_idx [8];
    int                    ar_count, n_issued, n_done, n_drop, n_len_err;

    rd_batch_top #(.fifo_depth(fifo_depth), .max_outstanding(max_out)) i_dut (.*);

    tb_axi_rd_slave i_slave (.*);

    // fibonacci lfsr, taps 16 14 13 11, one step per bit
    function automatic logic rand_bit();
        lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
        return lfsr[0];
    endfunction

    initial begin
        clock = 1'b0;
        forever #(period / 2) clock = ~clock;
    end

    // gaps on every handshake, ready about 3 cycles in 4
    always @(posedge clock) begin
        out_ready <= rand_bit() | rand_bit();
        ar_gate   <= rand_bit() | rand_bit();
        r_gate    <= rand_bit() | rand_bit();
    end

    // reference model and scoreboard
    always @(posedge clock) begin
        if (rst_n) begin
            // acc_q mirrors the fifo occupancy
            assert (req_ready == (acc_q.size() < fifo_depth)) else begin
                $display("[ERROR] req_ready exp %h got %h",
                         acc_q.size() < fifo_depth, req_ready);
                errors++;
            end
            if (req_valid && req_ready) acc_q.push_back(req);
            if (ar_valid && ar_ready) begin
                assert (acc_q.size() != 0 && ar == acc_q[0] && !busy_set[ar.id]) else begin
                    $display("[ERROR] ar exp %h got %h", acc_q.size() ? acc_q[0] : '0, ar);
                    errors++;
                end
                if (acc_q.size() != 0) void'(acc_q.pop_front());
                busy_set[ar.id]  = 1'b1;
                exp_addr[ar.id]  = ar.addr;
                exp_len[ar.id]   = ar.len;
                exp_short[ar.id] = (ar_count == short_idx);
                ar_count++;
                n_issued++;
            end
            if (pend_en) begin
                assert (acc_q.size() != 0 && pend_id == acc_q[0].id && busy_set[pend_id])
                else begin
                    $display("[ERROR] pend_id exp %h got %h",
                             acc_q.size() ? acc_q[0].id : 3'h0, pend_id);
                    errors++;
                end
                if (acc_q.size() != 0) void'(acc_q.pop_front());
                n_drop++;
            end
            if (out_valid && out_ready) begin
                int  i;
                logic exp_last;
                i        = beat_idx[out.id];
                exp_last = (i == int'(exp_len[out.id]) - int'(exp_short[out.id]));
                assert (busy_set[out.id]) else begin
                    $display("beat arrived for id %0d with no burst outstanding", out.id);
                    errors++;
                end
                assert (out.data == exp_addr[out.id] + i && out.last == exp_last) else begin
                    $display("[ERROR] out.data exp %h got %h, out.last exp %h got %h",
                             exp_addr[out.id] + i, out.data, exp_last, out.last);
                    errors++;
                end
                assert (out.len_err == (exp_last && exp_short[out.id])) else begin
                    $display("[ERROR] out.len_err exp %h got %h",
                             exp_last && exp_short[out.id], out.len_err);
                    errors++;
                end
                if (out.len_err) n_len_err++;
                beat_idx[out.id] = i + 1;
                if (out.last) begin
                    beat_idx[out.id] = 0;
                    busy_set[out.id] = 1'b0;    // id free at the last beat
                    n_done++;
                end
            end
        end
    end

    assert property (@(posedge clock) (!rst_n || $rose(rst_n)) |->
                     (!ar_valid && !pend_en && !out_valid))
    else begin
        $display("[ERROR] in reset ar_valid %h pend_en %h out_valid %h",
                 ar_valid, pend_en, out_valid);
        errors++;
    end

    assert property (@(posedge clock) disable iff (!rst_n)
                     ar_valid && !ar_ready |=> ar_valid && $stable(ar))
    else begin
        $display("AR request changed or dropped before its handshake");
        errors++;
    end

    assert property (@(posedge clock) disable iff (!rst_n)
                     r_ready == out_ready && out_valid == r_valid &&
                     (!r_valid || (out.id == r.id && out.data == r.data && out.last == r.last)))
    else begin
        $display("[ERROR] out %h r %h r_ready %h out_ready %h", out, r, r_ready, out_ready);
        errors++;
    end

    assert property (@(posedge clock) disable iff (!rst_n) pend_en |=> !pend_en)
    else begin
        $display("pend_en stayed high for more than one cycle");
        errors++;
    end

    assert property (@(posedge clock) disable iff (!rst_n) (n_issued - n_done) <= max_out)
    else begin
        $display("[ERROR] outstanding bursts %h over limit", n_issued - n_done);
        errors++;
    end

    task automatic send_req(input logic [2:0] i, input logic [31:0] a, input logic [7:0] n);
        req_valid <= 1'b1;
        req       <= '{id: i, addr: a, len: n};
        @(posedge clock);
        while (!req_ready) @(posedge clock);
        req_valid <= 1'b0;
    endtask

    task automatic drain();
        while (acc_q.size() != 0 || n_issued != n_done) @(posedge clock);
        repeat (4) @(posedge clock);
    endtask

    task automatic report_test(input string name, input int err_start);
        if (errors == err_start) $display("%s: ok", name);
        else $display("%s: %0d check(s) failed", name, errors - err_start);
    endtask

    initial begin
        int e0;
        int d0;
        rst_n = 1'b1;
        req_valid = 1'b0;
        req = '0;
        out_ready = 1'b0;
        ar_gate = 1'b0;
        r_gate = 1'b0;
        r_hold = 1'b0;
        short_idx = -1;
        errors = 0;
        {ar_count, n_issued, n_done, n_drop, n_len_err} = '0;
        #1 rst_n = 1'b0;
        repeat (5) @(posedge clock);
        rst_n <= 1'b1;
        repeat (3) @(posedge clock);
        report_test("reset", 0);

        // distinct ids, issued in acceptance order
        e0 = errors;
        for (int k = 0; k < 8; k++) send_req(3'(k), 32'h1000 * (k + 1), 8'(k % 4));
        drain();
        report_test("in-order issue", e0);

        // R withheld, a repeated id is dropped and the limit is reached
        e0 = errors;
        d0 = n_drop;
        r_hold <= 1'b1;
        send_req(3'd2, 32'h2000, 8'd1);
        send_req(3'd2, 32'h2100, 8'd0);
        send_req(3'd5, 32'h5000, 8'd2);
        send_req(3'd0, 32'h0100, 8'd0);
        send_req(3'd1, 32'h1100, 8'd3);
        send_req(3'd3, 32'h3100, 8'd1);
        send_req(3'd4, 32'h4100, 8'd2);
        send_req(3'd6, 32'h6100, 8'd0);
        send_req(3'd7, 32'h7100, 8'd1);
        // ids 6 and 7 stay in the fifo once the record is full
        while (n_issued - n_done < max_out) @(posedge clock);
        repeat (20) @(posedge clock);
        assert (n_drop == d0 + 1 && n_issued - n_done == max_out && acc_q.size() == 2)
        else begin
            $display("[ERROR] drops exp %h got %h, outstanding exp %h got %h, held exp %h got %h",
                     d0 + 1, n_drop, max_out, n_issued - n_done, 2, acc_q.size());
            errors++;
        end
        r_hold <= 1'b0;
        drain();
        report_test("drop and limit", e0);

        // second burst of this group ends a beat early
        e0 = errors;
        d0 = n_len_err;
        short_idx = ar_count + 1;
        send_req(3'd1, 32'hA000, 8'd3);
        send_req(3'd4, 32'hB000, 8'd2);
        send_req(3'd6, 32'hC000, 8'd0);
        drain();
        assert (n_len_err == d0 + 1) else begin
            $display("[ERROR] len_err beats exp %h got %h", d0 + 1, n_len_err);
            errors++;
        end
        report_test("short burst", e0);

        $display("tests run %0d, checks failed %0d", n_tests, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    initial begin
        #(watchdog_ns);
        $display("run stopped by the watchdog after %0d ns", watchdog_ns);
        $display("TEST FAILED");
        $finish;
    end

endmodule

//--- filelist.f
design/rd_batch_pkg.sv
design/req_fifo.sv
design/id_record.sv
design/rd_batch_gen.sv
design/rd_resp_track.sv
design/rd_batch_top.sv
test/tb_axi_rd_slave.sv
test/tb_rd_batch.sv
